//--- bench/mem_patterns.txt
# pc op wb addr store_data mis rdata resp delay req | rd_data rresp bresp wdata wstrb
# all hex; mis bit0 load bit1 store; req 0 none 1 read 2 write
00000100 0 1 00001000 00000000 0 12345680 0 0 1 ffffff80 0 0 00000000 0
00000104 0 1 00001001 00000000 0 1234f67f 1 3 1 fffffff6 1 0 00000000 0
00000108 0 1 00001002 00000000 0 127f0000 2 1 1 0000007f 2 0 00000000 0
0000010c 0 1 00001003 00000000 0 9a000000 3 5 1 ffffff9a 3 0 00000000 0
00000110 3 1 00002000 00000000 0 000000f0 0 0 1 000000f0 0 0 00000000 0
00000114 3 1 00002001 00000000 0 0000a500 0 2 1 000000a5 0 0 00000000 0
00000118 3 1 00002002 00000000 0 00c30000 1 4 1 000000c3 1 0 00000000 0
0000011c 3 1 00002003 00000000 0 e1000000 0 1 1 000000e1 0 0 00000000 0
00000120 1 1 00003000 00000000 0 00008001 0 0 1 ffff8001 0 0 00000000 0
00000124 1 1 00003002 00000000 0 7ffe0000 2 2 1 00007ffe 2 0 00000000 0
00000128 4 1 00004000 00000000 0 1234abcd 0 6 1 0000abcd 0 0 00000000 0
0000012c 4 1 00004002 00000000 0 fedc0000 3 1 1 0000fedc 3 0 00000000 0
00000130 2 1 00005000 00000000 0 deadbeef 0 3 1 deadbeef 0 0 00000000 0
00000134 1 1 00003006 00000000 0 c0010000 1 0 1 ffffc001 1 0 00000000 0
00000138 5 1 00006000 123456a7 0 00000000 1 2 2 00000000 0 1 a7a7a7a7 1
0000013c 5 1 00006001 00000042 0 00000000 0 0 2 00000000 0 0 42424242 2
00000140 5 1 00006002 ffffff13 0 00000000 2 4 2 00000000 0 2 13131313 4
00000144 5 1 00006003 87654321 0 00000000 3 1 2 00000000 0 3 21212121 8
00000148 6 1 00007000 1111beef 0 00000000 0 3 2 00000000 0 0 beefbeef 3
0000014c 6 1 00007002 0000cafe 0 00000000 1 0 2 00000000 0 1 cafecafe c
00000150 7 1 00008000 0badf00d 0 00000000 2 5 2 00000000 0 2 0badf00d f
00000154 0 0 0000abcd 00000000 0 00000000 0 0 0 0000abcd 0 0 00000000 0
00000158 7 2 12345678 55555555 0 00000000 0 0 0 12345678 0 0 00000000 0
0000015c 2 3 fffff000 00000000 0 00000000 0 0 0 fffff000 0 0 00000000 0
00000160 2 1 00009001 00000000 1 00000000 0 0 0 00000000 0 0 00000000 0
00000164 6 1 0000a003 0000beef 2 00000000 0 0 0 00000000 0 0 00000000 0
00000168 2 1 0000b004 00000000 0 01020304 0 6 1 01020304 0 0 00000000 0
0000016c 4 1 0000b006 00000000 0 80010000 1 2 1 00008001 1 0 00000000 0
00000170 0 0 00000042 00000000 0 00000000 0 0 0 00000042 0 0 00000000 0

//--- bench/mem_unit_tb.sv
`timescale 1ns/100ps

module mem_unit_tb
	import mem_pkg::*;
();

	localparam int MAX_PAT = 64;

	logic		clk;
	logic		reset;
	logic		valid_in;
	logic		ready_out;
	logic		valid_out;
	logic		ready_in;
	word_t		pc_ex;
	word_t		ir_ex;
	word_t		imm_ex;
	word_t		store_data_ex;
	word_t		alu_result_ex;
	reg_addr_t	rd_addr_ex;
	logic		rd_access_ex;
	wb_src_t	wb_src_ex;
	mem_op_t	mem_op_ex;
	resp_t		imem_rresp_ex;
	logic		illegal_inst_ex;
	logic		maligned_inst_addr_ex;
	logic		maligned_load_addr_ex;
	logic		maligned_store_addr_ex;
	logic		dmem_rd_req;
	logic		dmem_wr_req;
	word_t		dmem_addr;
	word_t		dmem_wdata;
	strb_t		dmem_wstrb;
	word_t		dmem_rdata;
	logic		dmem_rvalid;
	resp_t		dmem_rresp;
	logic		dmem_rready;
	logic		dmem_bvalid;
	resp_t		dmem_bresp;
	logic		dmem_bready;
	word_t		pc_mem;
	word_t		ir_mem;
	word_t		imm_mem;
	reg_addr_t	rd_addr_mem;
	word_t		rd_data_mem;
	logic		rd_access_mem;
	resp_t		imem_rresp_mem;
	logic		illegal_inst_mem;
	logic		maligned_inst_addr_mem;
	logic		maligned_load_addr_mem;
	logic		maligned_store_addr_mem;
	resp_t		dmem_rresp_mem;
	resp_t		dmem_bresp_mem;

	// one entry per pattern line.
	word_t		pat_pc [MAX_PAT];
	mem_op_t	pat_op [MAX_PAT];
	wb_src_t	pat_wb [MAX_PAT];
	word_t		pat_addr [MAX_PAT];
	word_t		pat_sdata [MAX_PAT];
	logic [1:0]	pat_mis [MAX_PAT];
	word_t		pat_rdata [MAX_PAT];
	resp_t		pat_resp [MAX_PAT];
	int		pat_dly [MAX_PAT];
	logic [1:0]	pat_req [MAX_PAT];
	word_t		exp_rd [MAX_PAT];
	resp_t		exp_rresp [MAX_PAT];
	resp_t		exp_bresp [MAX_PAT];
	word_t		exp_wdata [MAX_PAT];
	strb_t		exp_wstrb [MAX_PAT];

	int		n_pat;
	int		n_done;
	int		max_dly;
	int		limit_cycles;
	logic		loaded;
	int		exp_queue [$];

	// memory responder works on the instruction currently presented.
	word_t		cur_rdata;
	resp_t		cur_resp;
	int		cur_dly;

	mem_unit_top i_dut (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic report_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping simulation at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_resp(input string name, input resp_t exp, input resp_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_strb(input string name, input strb_t exp, input strb_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_reg_addr(input string name, input reg_addr_t exp,
		input reg_addr_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic load_patterns();
		int	fd;
		string	line;
		fd = $fopen("bench/mem_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file bench/mem_patterns.txt");
			report_failure();
		end
		n_pat = 0;
		max_dly = 0;
		while (n_pat < MAX_PAT && $fgets(line, fd) != 0) begin
			// comment and blank lines do not scan all fields.
			if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				pat_pc[n_pat], pat_op[n_pat], pat_wb[n_pat], pat_addr[n_pat],
				pat_sdata[n_pat], pat_mis[n_pat], pat_rdata[n_pat], pat_resp[n_pat],
				pat_dly[n_pat], pat_req[n_pat], exp_rd[n_pat], exp_rresp[n_pat],
				exp_bresp[n_pat], exp_wdata[n_pat], exp_wstrb[n_pat]) == 15) begin
				if (pat_dly[n_pat] > max_dly) begin
					max_dly = pat_dly[n_pat];
				end
				n_pat++;
			end
		end
		$fclose(fd);
		if (n_pat == 0) begin
			$display("the pattern file holds no instructions");
			report_failure();
		end
	endtask

	task automatic drive_pattern(input int i);
		pc_ex                  = pat_pc[i];
		ir_ex                  = 32'h0000_1013 ^ word_t'(i);
		imm_ex                 = ~pat_pc[i];
		store_data_ex          = pat_sdata[i];
		alu_result_ex          = pat_addr[i];
		rd_addr_ex             = reg_addr_t'(i);
		rd_access_ex           = i[0];
		imem_rresp_ex          = resp_t'(i);
		illegal_inst_ex        = i[2];
		maligned_inst_addr_ex  = i[3];
		wb_src_ex              = pat_wb[i];
		mem_op_ex              = pat_op[i];
		maligned_load_addr_ex  = pat_mis[i][0];
		maligned_store_addr_ex = pat_mis[i][1];
		cur_rdata              = pat_rdata[i];
		cur_resp               = pat_resp[i];
		cur_dly                = pat_dly[i];
		valid_in               = 1'b1;
	endtask

	// request levels, address and lanes while the instruction waits.
	task automatic check_request(input int i);
		check_flag("dmem_rd_req", pat_req[i] == 2'd1, dmem_rd_req);
		check_flag("dmem_wr_req", pat_req[i] == 2'd2, dmem_wr_req);
		check_flag("dmem_rready", pat_req[i] == 2'd1 && ready_in, dmem_rready);
		check_flag("dmem_bready", pat_req[i] == 2'd2 && ready_in, dmem_bready);
		check_flag("ready_out",
			ready_in && (pat_req[i] == 2'd0 || dmem_rvalid || dmem_bvalid), ready_out);
		if (pat_req[i] != 2'd0) begin
			check_word("dmem_addr", {pat_addr[i][31:2], 2'b00}, dmem_addr);
		end
		if (pat_req[i] == 2'd2) begin
			check_word("dmem_wdata", exp_wdata[i], dmem_wdata);
			check_strb("dmem_wstrb", exp_wstrb[i], dmem_wstrb);
		end
	endtask

	task automatic check_result(input int idx);
		check_word("pc_mem", pat_pc[idx], pc_mem);
		check_word("ir_mem", 32'h0000_1013 ^ word_t'(idx), ir_mem);
		check_word("imm_mem", ~pat_pc[idx], imm_mem);
		check_reg_addr("rd_addr_mem", reg_addr_t'(idx), rd_addr_mem);
		check_flag("rd_access_mem", idx[0], rd_access_mem);
		check_resp("imem_rresp_mem", resp_t'(idx), imem_rresp_mem);
		check_flag("illegal_inst_mem", idx[2], illegal_inst_mem);
		check_flag("maligned_inst_addr_mem", idx[3], maligned_inst_addr_mem);
		check_word("rd_data_mem", exp_rd[idx], rd_data_mem);
		check_resp("dmem_rresp_mem", exp_rresp[idx], dmem_rresp_mem);
		check_resp("dmem_bresp_mem", exp_bresp[idx], dmem_bresp_mem);
		check_flag("maligned_load_addr_mem", pat_mis[idx][0], maligned_load_addr_mem);
		check_flag("maligned_store_addr_mem", pat_mis[idx][1], maligned_store_addr_mem);
	endtask

	initial begin
		logic	accepted;
		reset = 1'b1;
		valid_in = 1'b0;
		pc_ex = '0;
		ir_ex = '0;
		imm_ex = '0;
		store_data_ex = '0;
		alu_result_ex = '0;
		rd_addr_ex = '0;
		rd_access_ex = 1'b1;
		wb_src_ex = SEL_ALU;
		mem_op_ex = MEM_LB;
		imem_rresp_ex = '0;
		illegal_inst_ex = 1'b0;
		maligned_inst_addr_ex = 1'b0;
		maligned_load_addr_ex = 1'b0;
		maligned_store_addr_ex = 1'b0;
		n_done = 0;
		loaded = 1'b0;
		load_patterns();
		limit_cycles = 12 + n_pat * (max_dly + 20);
		loaded = 1'b1;

		repeat (8) @(posedge clk);
		@(negedge clk);
		check_flag("ready_out", 1'b0, ready_out);
		check_flag("valid_out", 1'b0, valid_out);
		reset = 1'b0;
		@(negedge clk);
		check_flag("valid_out", 1'b0, valid_out);
		check_flag("dmem_rd_req", 1'b0, dmem_rd_req);
		check_flag("dmem_wr_req", 1'b0, dmem_wr_req);
		@(posedge clk);
		#1;

		for (int i = 0; i < n_pat; i++) begin
			drive_pattern(i);
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge clk);
				check_request(i);
				accepted = ready_out;
				@(posedge clk);
				#1;
			end
			exp_queue.push_back(i);
		end
		valid_in = 1'b0;

		wait (n_done == n_pat);
		@(negedge clk);
		check_flag("valid_out", 1'b0, valid_out);
		$display("*** TEST PASSED ***");
		$finish;
	end

	// random back-pressure from writeback, ready all through reset.
	initial begin
		ready_in = 1'b1;
		void'($urandom(71));
		forever begin
			@(posedge clk);
			#1;
			if (reset) begin
				ready_in = 1'b1;
			end else begin
				ready_in = ($urandom % 4) != 0;
			end
		end
	end

	// data memory: beat after the pattern's delay, held until taken.
	initial begin
		logic	is_rd;
		logic	consumed;
		dmem_rdata = '0;
		dmem_rvalid = 1'b0;
		dmem_rresp = '0;
		dmem_bvalid = 1'b0;
		dmem_bresp = '0;
		forever begin
			@(negedge clk);
			if (dmem_rd_req || dmem_wr_req) begin
				is_rd = dmem_rd_req;
				repeat (cur_dly) @(posedge clk);
				@(posedge clk);
				#1;
				if (is_rd) begin
					dmem_rdata = cur_rdata;
					dmem_rresp = cur_resp;
					dmem_rvalid = 1'b1;
				end else begin
					dmem_bresp = cur_resp;
					dmem_bvalid = 1'b1;
				end
				consumed = 1'b0;
				while (!consumed) begin
					@(negedge clk);
					consumed = (dmem_rvalid && dmem_rready) || (dmem_bvalid && dmem_bready);
				end
				@(posedge clk);
				#1;
				dmem_rvalid = 1'b0;
				dmem_bvalid = 1'b0;
				dmem_rdata = 32'h5a5a_a5a5;
			end
		end
	end

	// writeback side, in order and stable under back-pressure.
	initial begin
		logic	hold_valid;
		word_t	held_pc;
		word_t	held_rd;
		int		idx;
		hold_valid = 1'b0;
		forever begin
			@(negedge clk);
			if (hold_valid) begin
				check_word("pc_mem", held_pc, pc_mem);
				check_word("rd_data_mem", held_rd, rd_data_mem);
			end
			hold_valid = valid_out && !ready_in;
			held_pc = pc_mem;
			held_rd = rd_data_mem;
			if (valid_out && ready_in) begin
				if (exp_queue.size() == 0) begin
					$display("a result left the stage with no instruction outstanding");
					report_failure();
				end else begin
					idx = exp_queue.pop_front();
					check_result(idx);
					n_done++;
				end
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, the results stopped before all patterns were done");
		report_failure();
	end

endmodule

//--- hdl/load_format.sv
`timescale 1ns/100ps

module load_format
	import mem_pkg::*;
(
	input	word_t		rdata,
	input	logic [1:0]	byte_offset,
	input	mem_op_t	mem_op,
	output	word_t		load_data
);

	word_t	shifted;

	// bring the addressed byte down to lane 0.
	assign shifted = rdata >> {byte_offset, 3'b000};

	always_comb begin
		case (mem_op)
			MEM_LB: begin
				load_data = {{24{shifted[7]}}, shifted[7:0]};
			end
			MEM_LH: begin
				load_data = {{16{shifted[15]}}, shifted[15:0]};
			end
			MEM_LBU: begin
				load_data = {24'h000000, shifted[7:0]};
			end
			MEM_LHU: begin
				load_data = {16'h0000, shifted[15:0]};
			end
			default: begin
				// word loads and non-load codes pass through.
				load_data = shifted;
			end
		endcase
	end

endmodule

//--- hdl/mem_pkg.sv
package mem_pkg;

	// data word and byte address.
	typedef logic [31:0] word_t;

	// destination register index, one bit wider than the architectural file.
	typedef logic [5:0] reg_addr_t;

	// bus response code, zero is okay.
	typedef logic [1:0] resp_t;

	// one bit per byte lane.
	typedef logic [3:0] strb_t;

	typedef logic [2:0] mem_op_t;
	typedef logic [2:0] wb_src_t;

	// memory operation codes.
	localparam mem_op_t MEM_LB  = 3'd0;
	localparam mem_op_t MEM_LH  = 3'd1;
	localparam mem_op_t MEM_LW  = 3'd2;
	localparam mem_op_t MEM_LBU = 3'd3;
	localparam mem_op_t MEM_LHU = 3'd4;
	localparam mem_op_t MEM_SB  = 3'd5;
	localparam mem_op_t MEM_SH  = 3'd6;
	localparam mem_op_t MEM_SW  = 3'd7;

	// writeback source select.
	localparam wb_src_t SEL_ALU = 3'd0;
	localparam wb_src_t SEL_MEM = 3'd1;
	localparam wb_src_t SEL_PC4 = 3'd2;
	localparam wb_src_t SEL_IMM = 3'd3;

endpackage

//--- hdl/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
	import mem_pkg::*;
(
	input	logic		clk,
	input	logic		reset,

	input	logic		valid_in,
	output	logic		ready_out,
	output	logic		valid_out,
	input	logic		ready_in,

	input	word_t		pc_ex,
	input	word_t		ir_ex,
	input	word_t		imm_ex,
	input	word_t		alu_result_ex,
	input	reg_addr_t	rd_addr_ex,
	input	logic		rd_access_ex,
	input	wb_src_t	wb_src_ex,
	input	mem_op_t	mem_op_ex,
	input	resp_t		imem_rresp_ex,
	input	logic		illegal_inst_ex,
	input	logic		maligned_inst_addr_ex,
	input	logic		maligned_load_addr_ex,
	input	logic		maligned_store_addr_ex,

	// aligned and extended read data from load_format.
	input	word_t		load_data,

	output	logic		dmem_rd_req,
	output	logic		dmem_wr_req,
	output	word_t		dmem_addr,
	input	logic		dmem_rvalid,
	input	resp_t		dmem_rresp,
	output	logic		dmem_rready,
	input	logic		dmem_bvalid,
	input	resp_t		dmem_bresp,
	output	logic		dmem_bready,

	output	word_t		pc_mem,
	output	word_t		ir_mem,
	output	word_t		imm_mem,
	output	reg_addr_t	rd_addr_mem,
	output	word_t		rd_data_mem,
	output	logic		rd_access_mem,
	output	resp_t		imem_rresp_mem,
	output	logic		illegal_inst_mem,
	output	logic		maligned_inst_addr_mem,
	output	logic		maligned_load_addr_mem,
	output	logic		maligned_store_addr_mem,
	output	resp_t		dmem_rresp_mem,
	output	resp_t		dmem_bresp_mem
);

	logic	is_mem;
	logic	is_load_op;
	logic	misaligned;
	logic	stall;
	logic	accept;
	logic	drain;
	word_t	rd_data_next;

	assign is_mem     = wb_src_ex == SEL_MEM;
	assign is_load_op = mem_op_ex inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
	assign misaligned = maligned_load_addr_ex || maligned_store_addr_ex;

	// a flagged access never reaches the bus.
	assign dmem_rd_req = valid_in && is_mem && is_load_op && !misaligned;
	assign dmem_wr_req = valid_in && is_mem && !is_load_op && !misaligned;
	assign dmem_addr   = {alu_result_ex[31:2], 2'b00};

	// the beat is taken on the same edge that accepts the instruction.
	assign dmem_rready = dmem_rd_req && ready_in;
	assign dmem_bready = dmem_wr_req && ready_in;

	assign stall = (dmem_rd_req && !dmem_rvalid) || (dmem_wr_req && !dmem_bvalid);

	// nothing is taken from execute while in reset.
	assign ready_out = ready_in && !stall && !reset;

	assign accept = valid_in && ready_out;
	assign drain  = valid_out && ready_in;

	always_comb begin
		if (dmem_rd_req) begin
			rd_data_next = load_data;
		end else if (is_mem) begin
			rd_data_next = '0;
		end else begin
			rd_data_next = alu_result_ex;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out               <= 1'b0;
			pc_mem                  <= '0;
			ir_mem                  <= '0;
			imm_mem                 <= '0;
			rd_addr_mem             <= '0;
			rd_data_mem             <= '0;
			rd_access_mem           <= 1'b0;
			imem_rresp_mem          <= '0;
			illegal_inst_mem        <= 1'b0;
			maligned_inst_addr_mem  <= 1'b0;
			maligned_load_addr_mem  <= 1'b0;
			maligned_store_addr_mem <= 1'b0;
			dmem_rresp_mem          <= '0;
			dmem_bresp_mem          <= '0;
		end else if (accept) begin
			valid_out               <= 1'b1;
			pc_mem                  <= pc_ex;
			ir_mem                  <= ir_ex;
			imm_mem                 <= imm_ex;
			rd_addr_mem             <= rd_addr_ex;
			rd_data_mem             <= rd_data_next;
			rd_access_mem           <= rd_access_ex;
			imem_rresp_mem          <= imem_rresp_ex;
			illegal_inst_mem        <= illegal_inst_ex;
			maligned_inst_addr_mem  <= maligned_inst_addr_ex;
			maligned_load_addr_mem  <= maligned_load_addr_ex;
			maligned_store_addr_mem <= maligned_store_addr_ex;
			// response codes only for the access that happened.
			dmem_rresp_mem          <= dmem_rd_req ? dmem_rresp : resp_t'(0);
			dmem_bresp_mem          <= dmem_wr_req ? dmem_bresp : resp_t'(0);
		end else if (drain) begin
			valid_out               <= 1'b0;
			pc_mem                  <= '0;
			ir_mem                  <= '0;
			imm_mem                 <= '0;
			rd_addr_mem             <= '0;
			rd_data_mem             <= '0;
			rd_access_mem           <= 1'b0;
			imem_rresp_mem          <= '0;
			illegal_inst_mem        <= 1'b0;
			maligned_inst_addr_mem  <= 1'b0;
			maligned_load_addr_mem  <= 1'b0;
			maligned_store_addr_mem <= 1'b0;
			dmem_rresp_mem          <= '0;
			dmem_bresp_mem          <= '0;
		end
	end

endmodule

//--- hdl/mem_unit_top.sv
`timescale 1ns/100ps

module mem_unit_top
	import mem_pkg::*;
(
	input	logic		clk,
	input	logic		reset,

	input	logic		valid_in,
	output	logic		ready_out,
	output	logic		valid_out,
	input	logic		ready_in,

	input	word_t		pc_ex,
	input	word_t		ir_ex,
	input	word_t		imm_ex,
	input	word_t		store_data_ex,
	input	word_t		alu_result_ex,
	input	reg_addr_t	rd_addr_ex,
	input	logic		rd_access_ex,
	input	wb_src_t	wb_src_ex,
	input	mem_op_t	mem_op_ex,
	input	resp_t		imem_rresp_ex,
	input	logic		illegal_inst_ex,
	input	logic		maligned_inst_addr_ex,
	input	logic		maligned_load_addr_ex,
	input	logic		maligned_store_addr_ex,

	output	logic		dmem_rd_req,
	output	logic		dmem_wr_req,
	output	word_t		dmem_addr,
	output	word_t		dmem_wdata,
	output	strb_t		dmem_wstrb,
	input	word_t		dmem_rdata,
	input	logic		dmem_rvalid,
	input	resp_t		dmem_rresp,
	output	logic		dmem_rready,
	input	logic		dmem_bvalid,
	input	resp_t		dmem_bresp,
	output	logic		dmem_bready,

	output	word_t		pc_mem,
	output	word_t		ir_mem,
	output	word_t		imm_mem,
	output	reg_addr_t	rd_addr_mem,
	output	word_t		rd_data_mem,
	output	logic		rd_access_mem,
	output	resp_t		imem_rresp_mem,
	output	logic		illegal_inst_mem,
	output	logic		maligned_inst_addr_mem,
	output	logic		maligned_load_addr_mem,
	output	logic		maligned_store_addr_mem,
	output	resp_t		dmem_rresp_mem,
	output	resp_t		dmem_bresp_mem
);

	word_t	load_data;

	load_format i_load_format (
		.rdata       (dmem_rdata),
		.byte_offset (alu_result_ex[1:0]),
		.mem_op      (mem_op_ex),
		.load_data   (load_data)
	);

	store_lanes i_store_lanes (
		.store_data  (store_data_ex),
		.byte_offset (alu_result_ex[1:0]),
		.mem_op      (mem_op_ex),
		.wdata       (dmem_wdata),
		.wstrb       (dmem_wstrb)
	);

	mem_stage i_mem_stage (
		.clk                     (clk),
		.reset                   (reset),
		.valid_in                (valid_in),
		.ready_out               (ready_out),
		.valid_out               (valid_out),
		.ready_in                (ready_in),
		.pc_ex                   (pc_ex),
		.ir_ex                   (ir_ex),
		.imm_ex                  (imm_ex),
		.alu_result_ex           (alu_result_ex),
		.rd_addr_ex              (rd_addr_ex),
		.rd_access_ex            (rd_access_ex),
		.wb_src_ex               (wb_src_ex),
		.mem_op_ex               (mem_op_ex),
		.imem_rresp_ex           (imem_rresp_ex),
		.illegal_inst_ex         (illegal_inst_ex),
		.maligned_inst_addr_ex   (maligned_inst_addr_ex),
		.maligned_load_addr_ex   (maligned_load_addr_ex),
		.maligned_store_addr_ex  (maligned_store_addr_ex),
		.load_data               (load_data),
		.dmem_rd_req             (dmem_rd_req),
		.dmem_wr_req             (dmem_wr_req),
		.dmem_addr               (dmem_addr),
		.dmem_rvalid             (dmem_rvalid),
		.dmem_rresp              (dmem_rresp),
		.dmem_rready             (dmem_rready),
		.dmem_bvalid             (dmem_bvalid),
		.dmem_bresp              (dmem_bresp),
		.dmem_bready             (dmem_bready),
		.pc_mem                  (pc_mem),
		.ir_mem                  (ir_mem),
		.imm_mem                 (imm_mem),
		.rd_addr_mem             (rd_addr_mem),
		.rd_data_mem             (rd_data_mem),
		.rd_access_mem           (rd_access_mem),
		.imem_rresp_mem          (imem_rresp_mem),
		.illegal_inst_mem        (illegal_inst_mem),
		.maligned_inst_addr_mem  (maligned_inst_addr_mem),
		.maligned_load_addr_mem  (maligned_load_addr_mem),
		.maligned_store_addr_mem (maligned_store_addr_mem),
		.dmem_rresp_mem          (dmem_rresp_mem),
		.dmem_bresp_mem          (dmem_bresp_mem)
	);

endmodule

//--- hdl/store_lanes.sv
`timescale 1ns/100ps

module store_lanes
	import mem_pkg::*;
(
	input	word_t		store_data,
	input	logic [1:0]	byte_offset,
	input	mem_op_t	mem_op,
	output	word_t		wdata,
	output	strb_t		wstrb
);

	strb_t	base_strb;

	always_comb begin
		case (mem_op)
			MEM_SB: begin
				wdata     = {4{store_data[7:0]}};
				base_strb = 4'b0001;
			end
			MEM_SH: begin
				wdata     = {2{store_data[15:0]}};
				base_strb = 4'b0011;
			end
			MEM_SW: begin
				wdata     = store_data;
				base_strb = 4'b1111;
			end
			default: begin
				// loads and other codes write no bytes.
				wdata     = store_data;
				base_strb = 4'b0000;
			end
		endcase
	end

	// strobe starts at the addressed lane.
	assign wstrb = base_strb << byte_offset;

endmodule

//--- run.sh
#!/bin/sh
# Build the memory stage testbench with Verilator and run it.
# A $fatal in the testbench gives a nonzero exit status.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	--top-module mem_unit_tb \
	-f sources.f \
	-o mem_unit_sim

./obj_dir/mem_unit_sim

//--- sources.f
hdl/mem_pkg.sv
hdl/load_format.sv
hdl/store_lanes.sv
hdl/mem_stage.sv
hdl/mem_unit_top.sv
bench/mem_unit_tb.sv
